// File: all.f
+incdir+hw
hw/naval_game_pkg.sv
hw/naval_display_pkg.sv
hw/fleet_board.sv
hw/ship_life_tracker.sv
hw/turn_controller.sv
hw/naval_battle_top.sv
verif/tb_clock_gen.sv
verif/naval_battle_tb.sv

// File: verif/naval_battle_tb.sv
`timescale 1ns/1ns

`include "naval_macros.svh"

module naval_battle_tb;

	localparam int directed_fires   = 28;
	localparam int max_random_fires = 240;
	localparam int after_over_fires = 3;
	localparam int planned_fires    = directed_fires + max_random_fires + after_over_fires;
	localparam int timeout_cycles   = 40 * planned_fires + 200;

	typedef enum int {
		sel_turn, sel_over, sel_winner, sel_valid0, sel_valid1, sel_ship0, sel_ship1,
		sel_disp0, sel_disp1, sel_dead0, sel_dead1
	} sel_e;

	typedef struct packed {
		logic [31:0] due;     // Cycle count at which the value must show
		logic [7:0]  sel;
		logic [31:0] value;
	} check_entry_t;

	logic       en_put_barcos, en_check_life;
	logic       start, fire;
	logic [5:0] cmd_word;
	logic       turn, game_over, winner;
	logic       impact_valid_p0, impact_valid_p1;
	logic [2:0] impact_ship_p0, impact_ship_p1;
	logic [6:0] display_life_p0, display_life_p1;
	logic       dead_p0, dead_p1;

	integer       seed = 32'h2f5d7772;
	int           cycle = 0;
	check_entry_t pending [$];

	// Reference state of both fleets
	bit         model_armed, model_play, model_over, model_turn, model_winner;
	logic [2:0] model_size;
	logic [63:0] model_hits [2];
	logic [2:0] model_segs [2][`NAVAL_MAX_SHIPS];
	logic [2:0] model_lives [2];

	tb_clock_gen u_clk (
		.en_put_barcos (en_put_barcos),
		.en_check_life (en_check_life)
	);

	naval_battle_top UUT (.*);

	// ============================================================
	// Reference model
	// ============================================================
	function automatic logic [6:0] expected_digit(input bit armed, input logic [2:0] lives);
		if (!armed)
			return `NAVAL_SEG_BLANK;
		case (lives)
			3'd0:    return `NAVAL_SEG_0;
			3'd1:    return `NAVAL_SEG_1;
			3'd2:    return `NAVAL_SEG_2;
			3'd3:    return `NAVAL_SEG_3;
			3'd4:    return `NAVAL_SEG_4;
			3'd5:    return `NAVAL_SEG_5;
			default: return `NAVAL_SEG_BLANK;
		endcase
	endfunction

	// Returns {ship, lives, digit} for a shot on board p
	function automatic logic [12:0] ref_shot(input bit p, input logic [2:0] r,
		input logic [2:0] c);
		logic [2:0] ship;
		int         idx;
		idx  = int'(r) * `NAVAL_BOARD_DIM + int'(c);
		ship = 3'd0;
		if ((int'(r) + 1 <= int'(model_size)) && (c <= r) && !model_hits[p][idx])
			ship = r + 3'd1;   // Ship k lies in row k-1
		model_hits[p][idx] = 1'b1;
		if ((ship != 3'd0) && (model_segs[p][ship - 1] != 3'd0)) begin
			model_segs[p][ship - 1] = model_segs[p][ship - 1] - 3'd1;
			if (model_segs[p][ship - 1] == 3'd0)
				model_lives[p] = model_lives[p] - 3'd1;
		end
		return {ship, model_lives[p], expected_digit(model_armed, model_lives[p])};
	endfunction

	function automatic logic [31:0] observe(input int sel);
		case (sel)
			sel_turn:   return turn;
			sel_over:   return game_over;
			sel_winner: return winner;
			sel_valid0: return impact_valid_p0;
			sel_valid1: return impact_valid_p1;
			sel_ship0:  return impact_ship_p0;
			sel_ship1:  return impact_ship_p1;
			sel_disp0:  return display_life_p0;
			sel_disp1:  return display_life_p1;
			sel_dead0:  return dead_p0;
			default:    return dead_p1;
		endcase
	endfunction

	function automatic string sig_name(input int sel);
		case (sel)
			sel_turn:   return "turn";
			sel_over:   return "game_over";
			sel_winner: return "winner";
			sel_valid0: return "impact_valid_p0";
			sel_valid1: return "impact_valid_p1";
			sel_ship0:  return "impact_ship_p0";
			sel_ship1:  return "impact_ship_p1";
			sel_disp0:  return "display_life_p0";
			sel_disp1:  return "display_life_p1";
			sel_dead0:  return "dead_p0";
			default:    return "dead_p1";
		endcase
	endfunction

	// ============================================================
	// Checking
	// ============================================================
	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Something failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic expect_at(input int delay, input int sel, input logic [31:0] value);
		check_entry_t entry;
		entry.due   = cycle + delay;
		entry.sel   = sel;
		entry.value = value;
		pending.push_back(entry);
	endtask

	always @(posedge en_put_barcos)
		cycle <= cycle + 1;

	// Outputs only move on the rising edge, so the falling edge is a safe sample point
	always @(negedge en_put_barcos) begin
		int i;
		for (i = pending.size() - 1; i >= 0; i--) begin
			if (pending[i].due == cycle) begin
				check_value(sig_name(pending[i].sel), observe(pending[i].sel), pending[i].value);
				pending.delete(i);
			end
		end
	end

	always @(posedge en_put_barcos) begin
		if (cycle >= timeout_cycles) begin
			$display("Timeout after %0d cycles, the run never reached its end", timeout_cycles);
			$display("Something failed");
			$fatal(1, "timeout");
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic start_game(input logic [2:0] size);
		logic [2:0] clamped;
		integer     rnd;
		int         p;
		int         k;
		clamped  = ((size == 3'd0) || (size == 3'd6) || (size == 3'd7)) ? 3'd1 : size;
		rnd      = $random(seed);
		cmd_word = {rnd[2:0], size};   // Spare bits are don't care
		start    = 1'b1;
		model_armed  = 1'b1;
		model_size   = clamped;
		model_play   = 1'b1;
		model_over   = 1'b0;
		model_turn   = 1'b0;
		model_winner = 1'b0;
		for (p = 0; p < 2; p++) begin
			model_hits[p]  = '0;
			model_lives[p] = clamped;
			for (k = 1; k <= `NAVAL_MAX_SHIPS; k++)
				model_segs[p][k - 1] = (k <= clamped) ? 3'(k) : 3'd0;
			expect_at(1, sel_disp0 + p, expected_digit(1'b1, clamped));
			expect_at(1, sel_dead0 + p, 0);
		end
		expect_at(1, sel_turn, 0);
		expect_at(1, sel_over, 0);
		expect_at(1, sel_winner, 0);
		@(negedge en_put_barcos);
		start = 1'b0;
		repeat (2) @(negedge en_put_barcos);
	endtask

	// Holds fire for n cycles, only the first can be taken
	task automatic fire_burst(input logic [2:0] r, input logic [2:0] c, input int n);
		logic [12:0] pred;
		bit          tgt;
		int          k;
		cmd_word = {r, c};
		fire     = 1'b1;
		if (model_play) begin
			tgt        = !model_turn;   // Player 0 aims at board 1
			pred       = ref_shot(tgt, r, c);
			model_turn = !model_turn;
			expect_at(1, sel_valid0 + tgt, 1);
			expect_at(1, sel_valid0 + !tgt, 0);
			expect_at(1, sel_ship0 + tgt, pred[12:10]);
			expect_at(1, sel_turn, model_turn);
			expect_at(2, sel_disp0 + tgt, pred[6:0]);
			expect_at(2, sel_dead0 + tgt, pred[9:7] == 3'd0);
			if (pred[9:7] == 3'd0) begin
				model_play   = 1'b0;
				model_over   = 1'b1;
				model_winner = !tgt;
				expect_at(3, sel_over, 1);
				expect_at(3, sel_winner, model_winner);
			end
		end else begin
			for (k = 0; k < 2; k++) begin
				expect_at(1, sel_valid0 + k, 0);
				expect_at(2, sel_disp0 + k, expected_digit(model_armed, model_lives[k]));
			end
			expect_at(1, sel_turn, model_turn);
			expect_at(1, sel_over, model_over);
			expect_at(1, sel_winner, model_winner);
		end
		for (k = 2; k <= n; k++) begin
			expect_at(k, sel_valid0, 0);
			expect_at(k, sel_valid1, 0);
			expect_at(k, sel_turn, model_turn);
		end
		repeat (n) @(negedge en_put_barcos);
		fire = 1'b0;
		repeat (5 - n) @(negedge en_put_barcos);
	endtask

	initial begin
		integer rnd;
		int     p;
		int     k;
		int     c;
		int     n;
		start    = 1'b0;
		fire     = 1'b0;
		cmd_word = '0;
		model_armed  = 1'b0;
		model_play   = 1'b0;
		model_over   = 1'b0;
		model_turn   = 1'b0;
		model_winner = 1'b0;
		model_size   = '0;
		for (p = 0; p < 2; p++) begin
			model_hits[p]  = '0;
			model_lives[p] = '0;
			for (k = 0; k < `NAVAL_MAX_SHIPS; k++)
				model_segs[p][k] = '0;
		end
		@(negedge en_check_life);
		@(negedge en_put_barcos);

		for (p = 0; p < 2; p++) begin
			expect_at(1, sel_disp0 + p, `NAVAL_SEG_BLANK);
			expect_at(1, sel_dead0 + p, 0);
		end
		fire_burst(3'd0, 3'd0, 1);   // Idle, ignored
		for (n = 0; n < 8; n++)
			start_game(3'(n));

		// Player 0 sinks ships 1 to 4, player 1 fires into water
		start_game(3'd5);
		n = 0;
		for (k = 1; k < `NAVAL_MAX_SHIPS; k++) begin
			for (c = 0; c < k; c++) begin
				fire_burst(3'(k - 1), 3'(c), 1);
				fire_burst(3'(7 - n / 8), 3'(n % 8), 1);
				n++;
			end
		end
		fire_burst(3'd0, 3'd0, 1);   // Repeat on a sunk cell
		fire_burst(3'd0, 3'd5, 1);
		fire_burst(3'd4, 3'd5, 1);
		fire_burst(3'd1, 3'd1, 1);
		fire_burst(3'd1, 3'd1, 1);
		fire_burst(3'd6, 3'd3, 4);
		fire_burst(3'd2, 3'd1, 3);

		// ============================================================
		// Random game on the upper left 4x4 corner
		// ============================================================
		start_game(3'd3);
		n = 0;
		while (!model_over && (n < max_random_fires)) begin
			rnd = $random(seed);
			fire_burst({1'b0, rnd[1:0]}, {1'b0, rnd[3:2]}, 1);
			n++;
		end
		if (!model_over) begin
			$display("Random game sank no fleet within %0d shots", n);
			$display("Something failed");
			$fatal(1, "random game did not finish");
		end
		for (n = 0; n < after_over_fires; n++)
			fire_burst(3'(n), 3'd0, 1);

		@(negedge en_put_barcos);
		if (pending.size() != 0) begin
			$display("%0d checks were never sampled", pending.size());
			$display("Something failed");
			$fatal(1, "checks left over");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
	output logic en_put_barcos,
	output logic en_check_life
);

	localparam int half_period  = 5;   // 10 ns clock
	localparam int reset_cycles = 4;

	initial begin
		en_put_barcos = 1'b0;
		forever #half_period en_put_barcos = ~en_put_barcos;
	end

	// Release on a falling edge so the first active edge sees a clean reset
	initial begin
		en_check_life = 1'b1;
		repeat (reset_cycles) @(posedge en_put_barcos);
		@(negedge en_put_barcos);
		en_check_life = 1'b0;
	end

endmodule

// File: hw/naval_battle_top.sv
`timescale 1ns/1ns

module naval_battle_top
	import naval_game_pkg::*, naval_display_pkg::*;
(
	input  logic       en_put_barcos,
	input  logic       en_check_life,
	input  logic       start,
	input  logic       fire,
	input  logic [5:0] cmd_word,
	output logic       turn,
	output logic       game_over,
	output logic       winner,
	output logic       impact_valid_p0,
	output logic       impact_valid_p1,
	output ship_id_t   impact_ship_p0,
	output ship_id_t   impact_ship_p1,
	output seg7_t      display_life_p0,
	output seg7_t      display_life_p1,
	output logic       dead_p0,
	output logic       dead_p1
);

	logic       load;
	logic [2:0] fleet_size;
	logic       shot_p0;
	logic       shot_p1;
	logic [2:0] row;
	logic [2:0] col;

	turn_controller u_ctrl (
		.en_put_barcos (en_put_barcos),
		.en_check_life (en_check_life),
		.start         (start),
		.fire          (fire),
		.cmd_word      (cmd_word),
		.dead_p0       (dead_p0),
		.dead_p1       (dead_p1),
		.load          (load),
		.fleet_size    (fleet_size),
		.shot_p0       (shot_p0),
		.shot_p1       (shot_p1),
		.row           (row),
		.col           (col),
		.turn          (turn),
		.game_over     (game_over),
		.winner        (winner)
	);

	// ============================================================
	// Player 0
	// ============================================================
	fleet_board u_board_p0 (
		.en_put_barcos (en_put_barcos),
		.en_check_life (en_check_life),
		.load          (load),
		.fleet_size    (fleet_size),
		.shot          (shot_p0),
		.row           (row),
		.col           (col),
		.impact_valid  (impact_valid_p0),
		.impact_ship   (impact_ship_p0)
	);

	ship_life_tracker u_life_p0 (
		.en_put_barcos (en_put_barcos),
		.en_check_life (en_check_life),
		.load          (load),
		.fleet_size    (fleet_size),
		.impact_valid  (impact_valid_p0),
		.impact_ship   (impact_ship_p0),
		.array_life    (),                 // Per-ship counts stay internal
		.display_life  (display_life_p0),
		.dead          (dead_p0)
	);

	// ============================================================
	// Player 1
	// ============================================================
	fleet_board u_board_p1 (
		.en_put_barcos (en_put_barcos),
		.en_check_life (en_check_life),
		.load          (load),
		.fleet_size    (fleet_size),
		.shot          (shot_p1),
		.row           (row),
		.col           (col),
		.impact_valid  (impact_valid_p1),
		.impact_ship   (impact_ship_p1)
	);

	ship_life_tracker u_life_p1 (
		.en_put_barcos (en_put_barcos),
		.en_check_life (en_check_life),
		.load          (load),
		.fleet_size    (fleet_size),
		.impact_valid  (impact_valid_p1),
		.impact_ship   (impact_ship_p1),
		.array_life    (),
		.display_life  (display_life_p1),
		.dead          (dead_p1)
	);

endmodule

// File: hw/turn_controller.sv
`timescale 1ns/1ns

`include "naval_macros.svh"

module turn_controller
	import naval_game_pkg::*;
(
	input  logic       en_put_barcos,
	input  logic       en_check_life,
	input  logic       start,
	input  logic       fire,
	input  cmd_word_u  cmd_word,
	input  logic       dead_p0,
	input  logic       dead_p1,
	output logic       load,
	output logic [2:0] fleet_size,
	output logic       shot_p0,
	output logic       shot_p1,
	output logic [2:0] row,
	output logic [2:0] col,
	output logic       turn,
	output logic       game_over,
	output logic       winner
);

	localparam logic [1:0] busy_cycles = 2'd3;

	game_phase_e phase_q;
	logic [1:0]  busy_q;
	logic        turn_q;     // Player whose shot is next
	logic        winner_q;
	logic [2:0]  size_raw;
	logic        accept;

	// ============================================================
	// Decode of the switch word
	// ============================================================
	assign size_raw   = cmd_word.setup.fleet_size;
	assign fleet_size = ((size_raw == 3'd0) || (size_raw > 3'(`NAVAL_MAX_SHIPS)))
		? 3'd1 : size_raw;
	assign row        = cmd_word.shot.row;
	assign col        = cmd_word.shot.col;

	assign load    = start;
	// Start wins over a fire in the same cycle
	assign accept  = fire && !start && (phase_q == phase_play) && (busy_q == 2'd0);
	assign shot_p0 = accept && turn_q;    // Player 1 fires at board 0
	assign shot_p1 = accept && !turn_q;

	always_ff @(posedge en_put_barcos or posedge en_check_life) begin
		if (en_check_life) begin
			phase_q  <= phase_idle;
			busy_q   <= '0;
			turn_q   <= 1'b0;
			winner_q <= 1'b0;
		end else if (start) begin
			phase_q  <= phase_play;
			busy_q   <= '0;
			turn_q   <= 1'b0;
			winner_q <= 1'b0;
		end else begin
			if (accept) begin
				busy_q <= busy_cycles;
				turn_q <= ~turn_q;
			end else if (busy_q != 2'd0) begin
				busy_q <= busy_q - 2'd1;
			end
			if ((phase_q == phase_play) && (dead_p0 || dead_p1)) begin
				phase_q  <= phase_over;
				winner_q <= dead_p0;   // The side still alive
			end
		end
	end

	assign turn      = turn_q;
	assign game_over = (phase_q == phase_over);
	assign winner    = winner_q;

	// Only one fleet can ever be sunk
	a_one_dead: assert property (
		@(posedge en_put_barcos) disable iff (en_check_life)
		!(dead_p0 && dead_p1)
	);

	// The declared winner never has its fleet sunk
	a_winner_alive: assert property (
		@(posedge en_put_barcos) disable iff (en_check_life)
		game_over |-> !(winner ? dead_p1 : dead_p0)
	);

endmodule

// File: hw/ship_life_tracker.sv
`timescale 1ns/1ns

`include "naval_macros.svh"

module ship_life_tracker
	import naval_game_pkg::*, naval_display_pkg::*;
(
	input  logic       en_put_barcos,
	input  logic       en_check_life,
	input  logic       load,
	input  logic [2:0] fleet_size,
	input  logic       impact_valid,
	input  ship_id_t   impact_ship,
	output logic [2:0] array_life [`NAVAL_MAX_SHIPS],
	output seg7_t      display_life,
	output logic       dead
);

	logic [2:0] segs_q [`NAVAL_MAX_SHIPS];   // Entry k-1 belongs to ship k
	logic [2:0] segs_n [`NAVAL_MAX_SHIPS];
	logic [2:0] lives_q;
	logic [2:0] lives_n;
	logic       armed_q;                     // Set by the first load
	logic       armed_n;
	logic [2:0] hit_idx;
	logic       hit_ok;
	logic [2:0] alive_cnt;

	assign hit_idx = impact_ship - 3'd1;
	assign hit_ok  = impact_valid && (impact_ship != '0)
		&& (impact_ship <= 3'(`NAVAL_MAX_SHIPS)) && (segs_q[hit_idx] != 3'd0);
	assign armed_n = armed_q | load;

	// ============================================================
	// Next segment counts and lives
	// ============================================================
	always_comb begin
		segs_n  = segs_q;
		lives_n = lives_q;
		if (load) begin
			for (int k = 0; k < `NAVAL_MAX_SHIPS; k++)
				segs_n[k] = (k < fleet_size) ? 3'(k + 1) : 3'd0;
			lives_n = fleet_size;
		end else if (hit_ok) begin
			segs_n[hit_idx] = segs_q[hit_idx] - 3'd1;
			if (segs_q[hit_idx] == 3'd1)
				lives_n = lives_q - 3'd1;   // Last segment gone, ship sunk
		end
	end

	always_ff @(posedge en_put_barcos or posedge en_check_life) begin
		if (en_check_life) begin
			segs_q       <= '{default: 3'd0};
			lives_q      <= '0;
			armed_q      <= 1'b0;
			display_life <= `NAVAL_SEG_BLANK;
		end else begin
			segs_q       <= segs_n;
			lives_q      <= lives_n;
			armed_q      <= armed_n;
			display_life <= armed_n ? life_to_seg(lives_n) : `NAVAL_SEG_BLANK;
		end
	end

	assign array_life = segs_q;
	assign dead       = armed_q && (lives_q == 3'd0);

	// Ships still afloat
	always_comb begin
		alive_cnt = '0;
		for (int k = 0; k < `NAVAL_MAX_SHIPS; k++)
			alive_cnt = alive_cnt + 3'(segs_q[k] != 3'd0);
	end

	// Holds only because the controller clamps the fleet size
	a_lives_max: assert property (
		@(posedge en_put_barcos) disable iff (en_check_life)
		lives_q <= 3'(`NAVAL_MAX_SHIPS)
	);

	a_lives_match: assert property (
		@(posedge en_put_barcos) disable iff (en_check_life)
		lives_q == alive_cnt
	);

endmodule

// File: hw/fleet_board.sv
`timescale 1ns/1ns

`include "naval_macros.svh"

module fleet_board
	import naval_game_pkg::*;
(
	input  logic       en_put_barcos,
	input  logic       en_check_life,
	input  logic       load,
	input  logic [2:0] fleet_size,
	input  logic       shot,
	input  logic [2:0] row,
	input  logic [2:0] col,
	output logic       impact_valid,
	output ship_id_t   impact_ship
);

	localparam int cells  = `NAVAL_BOARD_DIM * `NAVAL_BOARD_DIM;
	localparam int cell_w = $clog2(cells);

	logic [cells-1:0]  hit_q;      // One bit per cell already fired on
	logic [2:0]        size_q;
	logic [cell_w-1:0] cell_idx;
	logic              on_ship;
	ship_id_t          ship_here;

	// ============================================================
	// Fixed layout: ship k sits in row k-1, columns 0 to k-1
	// ============================================================
	assign cell_idx = cell_w'(row) * cell_w'(`NAVAL_BOARD_DIM) + cell_w'(col);
	assign on_ship  = (row < size_q) && (col <= row);

	always_comb begin
		if (on_ship && !hit_q[cell_idx])
			ship_here = ship_id_t'(row + 3'd1);
		else
			ship_here = '0;    // Water or a repeat
	end

	always_ff @(posedge en_put_barcos or posedge en_check_life) begin
		if (en_check_life) begin
			hit_q        <= '0;
			size_q       <= '0;
			impact_valid <= 1'b0;
			impact_ship  <= '0;
		end else begin
			impact_valid <= shot;
			impact_ship  <= shot ? ship_here : '0;
			if (load) begin
				hit_q  <= '0;
				size_q <= fleet_size;
			end else if (shot) begin
				hit_q[cell_idx] <= 1'b1;
			end
		end
	end

	// A reload never shares its cycle with a shot
	a_no_shot_on_load: assert property (
		@(posedge en_put_barcos) disable iff (en_check_life)
		!(shot && load)
	);

	// Only a clamped fleet size is ever stored
	a_size_in_range: assert property (
		@(posedge en_put_barcos) disable iff (en_check_life)
		load |=> (size_q >= 3'd1) && (size_q <= 3'(`NAVAL_MAX_SHIPS))
	);

endmodule

// File: hw/naval_display_pkg.sv
`include "naval_macros.svh"

package naval_display_pkg;

	// Active low, g in the top bit
	typedef logic [6:0] seg7_t;

	// Lives count to digit, anything past the fleet max is blank
	function automatic seg7_t life_to_seg(input logic [2:0] lives);
		seg7_t seg;
		case (lives)
			3'd0:    seg = `NAVAL_SEG_0;
			3'd1:    seg = `NAVAL_SEG_1;
			3'd2:    seg = `NAVAL_SEG_2;
			3'd3:    seg = `NAVAL_SEG_3;
			3'd4:    seg = `NAVAL_SEG_4;
			3'd5:    seg = `NAVAL_SEG_5;
			default: seg = `NAVAL_SEG_BLANK;
		endcase
		return seg;
	endfunction

endpackage

// File: hw/naval_game_pkg.sv
package naval_game_pkg;

	// 0 is water or a miss, 1 to 5 name a ship
	typedef logic [2:0] ship_id_t;

	// ============================================================
	// Switch word, read as setup or as a shot
	// ============================================================
	typedef struct packed {
		logic [2:0] spare;
		logic [2:0] fleet_size;
	} setup_view_t;

	typedef struct packed {
		logic [2:0] row;
		logic [2:0] col;
	} shot_view_t;

	typedef union packed {
		setup_view_t setup;
		shot_view_t  shot;
	} cmd_word_u;

	typedef enum logic [1:0] {
		phase_idle = 2'd0,
		phase_play = 2'd1,
		phase_over = 2'd2
	} game_phase_e;

endpackage

// File: hw/naval_macros.svh
`ifndef NAVAL_MACROS_SVH
`define NAVAL_MACROS_SVH

// ============================================================
// Game sizing
// ============================================================
`define NAVAL_MAX_SHIPS 5   // Also the max number of lives
`define NAVAL_BOARD_DIM 8   // Cells per side

// ============================================================
// Seven-segment codes, active low, segment g in bit 6
// ============================================================
`define NAVAL_SEG_BLANK 7'b1111111
`define NAVAL_SEG_0     7'b1000000
`define NAVAL_SEG_1     7'b1111001
`define NAVAL_SEG_2     7'b0100100
`define NAVAL_SEG_3     7'b0110000
`define NAVAL_SEG_4     7'b0011001
`define NAVAL_SEG_5     7'b0010010

`endif
